//--- compile.f
logic/pfb_pkg.sv
logic/arm_feeder.sv
logic/tap_history.sv
logic/coef_bank.sv
logic/polyphase_mac.sv
logic/stream_fifo.sv
logic/pfb_top.sv
test/pfb_checker.sv
test/pfb_tb.sv

//--- test/pfb_testdata.txt
# tags: Z fft_size, J junk words ending in r_last, R tap0..tap3 coefficients (hex), T test, M stall
# S data phase last exp_i exp_q, all hex, expected values follow the filter arithmetic
Z 8
R 10000 08000 04000 02000
T 0
M 0
S 01000010 0 0 0080 0008
S 01000020 1 0 0080 0010
S 01000030 2 0 0080 0018
S 01000040 3 0 0080 0020
S 01000050 4 0 0000 0000
S 01000060 5 0 0000 0000
S 01000070 6 0 0000 0000
S 01000080 7 1 0000 0000
S 02000010 0 0 0140 000c
S 02000020 1 0 0140 0018
S 02000030 2 0 0140 0024
S 02000040 3 0 0140 0030
S 02000050 4 0 0080 0028
S 02000060 5 0 0080 0030
S 02000070 6 0 0080 0038
S 02000080 7 1 0080 0040
W
T 1
M 1
S 03000010 0 0 0220 000e
S 03000020 1 0 0220 001c
S 03000030 2 0 0220 002a
S 03000040 3 0 0220 0038
S 03000050 4 0 0140 003c
S 03000060 5 0 0140 0048
S 03000070 6 0 0140 0054
S 03000080 7 1 0140 0060
S 04000010 8 0 0310 000f
S 04000020 9 0 0310 001e
S 04000030 a 0 0310 002d
S 04000040 b 0 0310 003c
S 04000050 c 0 0220 0046
S 04000060 d 0 0220 0054
S 04000070 e 0 0220 0062
S 04000080 f 1 0220 0070
W
M 0
Z 16
J 3
R 08000 30000 00000 00000
T 2
S 04000010 0 0 0100 0004
S 04000020 1 0 0100 0008
S 04000030 2 0 0100 000c
S 04000040 3 0 0100 0010
S 04000050 4 0 0100 0014
S 04000060 5 0 0100 0018
S 04000070 6 0 0100 001c
S 04000080 7 1 0100 0020
W

//--- test/pfb_tb.sv
// Testbench for the polyphase filter bank; runs the stimulus and expected results from the data file.
module pfb_tb
  import pfb_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 5000;

  logic clk = 1'b0;
  logic sync_reset, s_valid, s_last, s_ready, r_valid, r_last, r_ready;
  logic m_valid, m_last, m_ready, exp_push, exp_last;
  logic [SIZE_W-1:0] fft_size;
  logic [SAMPLE_W-1:0] s_data, m_data, exp_data;
  logic [PHASE_W-1:0] s_phase, m_phase, exp_phase;
  logic [COEF_W-1:0] r_data;
  logic [1:0] exp_test;
  int pending, chk_errors, chk_count, tb_errors, seed, code, fd, num;
  logic stall_mode, timed_out, saw_backpressure;
  logic [63:0] tag;
  logic [8*128-1:0] line;
  logic [COEF_W-1:0] coef [NUM_TAPS];
  logic [SAMPLE_W-1:0] in_word;
  logic [15:0] exp_i, exp_q;
  logic [3:0] in_phase;
  logic in_last;

  always #20 clk = ~clk;

  pfb_top pfb_top_inst (
    .clk(clk), .sync_reset(sync_reset), .fft_size(fft_size),
    .s_valid(s_valid), .s_data(s_data), .s_phase(s_phase), .s_last(s_last), .s_ready(s_ready),
    .r_valid(r_valid), .r_data(r_data), .r_last(r_last), .r_ready(r_ready),
    .m_valid(m_valid), .m_data(m_data), .m_phase(m_phase), .m_last(m_last), .m_ready(m_ready)
  );

  pfb_checker pfb_checker_inst (
    .clk(clk), .sync_reset(sync_reset), .m_valid(m_valid), .m_data(m_data),
    .m_phase(m_phase), .m_last(m_last), .m_ready(m_ready),
    .exp_push(exp_push), .exp_data(exp_data), .exp_phase(exp_phase), .exp_last(exp_last),
    .exp_test(exp_test), .pending(pending), .error_count(chk_errors), .check_count(chk_count)
  );

  // while stalling the consumer holds off until input ready falls, then takes one cycle in eight.
  always @(negedge clk) begin
    m_ready <= stall_mode ? (saw_backpressure && (($random(seed) & 7) == 0)) : 1'b1;
  end

  task automatic apply_reset(input int size);
    sync_reset = 1'b1;
    fft_size = SIZE_W'(size);
    repeat (3) @(negedge clk);
    sync_reset = 1'b0;
    if (m_valid !== 1'b0 || s_ready !== 1'b1) begin
      tb_errors++;
      $display("FAIL reset_state expected m_valid=0 s_ready=1 actual m_valid=%b s_ready=%b",
        m_valid, s_ready);
    end
    @(negedge clk);
    if (r_ready !== 1'b1) begin
      tb_errors++;
      $display("FAIL reset_state expected r_ready=1 actual r_ready=%b", r_ready);
    end
  endtask

  task automatic load_word(input logic [COEF_W-1:0] word, input logic last);
    int waited;
    waited = 0;
    while (!r_ready && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        $display("timeout while waiting for r_ready");
      end
    end
    r_valid = 1'b1;
    r_data = word;
    r_last = last;
    @(negedge clk);
    r_valid = 1'b0;
    r_last = 1'b0;
  endtask

  task automatic send_sample(input logic [SAMPLE_W-1:0] word, input logic [3:0] phase,
                             input logic last, input logic [SAMPLE_W-1:0] expected);
    int waited;
    waited = 0;
    while (!s_ready && !timed_out) begin
      saw_backpressure = 1'b1;
      if (pending < ALMOST_FULL_LEVEL) begin
        tb_errors++;
        $display("s_ready is low with only %0d results outstanding", pending);
      end
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        $display("timeout while waiting for s_ready");
      end
    end
    s_valid = 1'b1;
    s_data = word;
    s_phase = phase;
    s_last = last;
    exp_push = 1'b1;
    exp_data = expected;
    exp_phase = phase & PHASE_W'(fft_size - 1);
    exp_last = last;
    @(negedge clk);
    s_valid = 1'b0;
    exp_push = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending != 0 && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        $display("timeout with %0d expected results never seen at the output", pending);
      end
    end
    if (stall_mode && !saw_backpressure) begin
      tb_errors++;
      $display("s_ready never fell while the output was stalled");
    end
  endtask

  initial begin
    sync_reset = 1'b1;
    fft_size = SIZE_W'(8);
    {s_valid, s_last, r_valid, r_last, m_ready, exp_push, exp_last} = '0;
    s_data = '0;
    s_phase = '0;
    r_data = '0;
    exp_data = '0;
    exp_phase = '0;
    exp_test = '0;
    {stall_mode, timed_out, saw_backpressure} = '0;
    tb_errors = 0;
    seed = 32'h8e09a0d9;
    @(negedge clk);
    fd = $fopen("test/pfb_testdata.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("cannot open the test data file");
    end else begin
      while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
        case (tag)
          "#": code = $fgets(line, fd);
          "Z": begin
            code = $fscanf(fd, "%d", num);
            apply_reset(num);
          end
          "J": begin
            code = $fscanf(fd, "%d", num);
            for (int j = 0; j < num; j++) load_word('1 >> 1, j == num - 1);
          end
          "R": begin
            code = $fscanf(fd, "%h %h %h %h", coef[0], coef[1], coef[2], coef[3]);
            for (int j = 0; j < COEF_COUNT; j++) begin
              load_word(coef[j / MAX_PHASES], j == COEF_COUNT - 1);
            end
          end
          "T": begin
            code = $fscanf(fd, "%d", num);
            exp_test = 2'(num);
          end
          "M": begin
            code = $fscanf(fd, "%d", num);
            stall_mode = (num != 0);
            saw_backpressure = 1'b0;
          end
          "S": begin
            code = $fscanf(fd, "%h %h %h %h %h", in_word, in_phase, in_last, exp_i, exp_q);
            send_sample(in_word, in_phase, in_last, {exp_i, exp_q});
          end
          "W": wait_drain();
          default: begin
            tb_errors++;
            $display("unknown tag in the test data file");
          end
        endcase
      end
      $fclose(fd);
    end
    if (!timed_out && pending != 0) begin
      tb_errors++;
      $display("%0d expected results were left unchecked at the end", pending);
    end
    $display("checks=%0d checker_errors=%0d testbench_errors=%0d timeout=%0b",
      chk_count, chk_errors, tb_errors, timed_out);
    if (chk_errors == 0 && tb_errors == 0 && !timed_out && chk_count > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- test/pfb_checker.sv
// Scoreboard for the filter bank testbench; compares each output handshake with the next expected result.
module pfb_checker
  import pfb_pkg::*;
(
  input  logic                clk,
  input  logic                sync_reset,
  input  logic                m_valid,
  input  logic [SAMPLE_W-1:0] m_data,
  input  logic [PHASE_W-1:0]  m_phase,
  input  logic                m_last,
  input  logic                m_ready,
  input  logic                exp_push,
  input  logic [SAMPLE_W-1:0] exp_data,
  input  logic [PHASE_W-1:0]  exp_phase,
  input  logic                exp_last,
  input  logic [1:0]          exp_test,
  output int                  pending,
  output int                  error_count,
  output int                  check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // record layout is {test, last, phase, data}.
  logic [SAMPLE_W+PHASE_W+2:0] expected_q [$];

  function automatic string test_name(input logic [1:0] id);
    case (id)
      2'd0: test_name = "m8_basic";
      2'd1: test_name = "m8_stalls";
      default: test_name = "m16_reload";
    endcase
  endfunction

  initial begin
    pending = 0;
    error_count = 0;
    check_count = 0;
  end

  always @(posedge clk) begin : compare
    logic [SAMPLE_W+PHASE_W+2:0] rec;
    if (exp_push) begin
      expected_q.push_back({exp_test, exp_last, exp_phase, exp_data});
    end
    if (!sync_reset && m_valid && m_ready) begin
      check_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("output %h taken while no result was expected", m_data);
      end else begin
        rec = expected_q.pop_front();
        if ({m_last, m_phase, m_data} !== rec[SAMPLE_W+PHASE_W:0]) begin
          error_count++;
          $display("FAIL %s expected data=%h phase=%0d last=%0b actual data=%h phase=%0d last=%0b",
            test_name(rec[SAMPLE_W+PHASE_W+2:SAMPLE_W+PHASE_W+1]),
            rec[SAMPLE_W-1:0], rec[SAMPLE_W+PHASE_W-1:SAMPLE_W], rec[SAMPLE_W+PHASE_W],
            m_data, m_phase, m_last);
        end
      end
    end
    pending = expected_q.size();
  end

endmodule

//--- logic/pfb_top.sv
// Top level of the 2x-oversampled polyphase filter bank, joining all stages to the streams.
module pfb_top
  import pfb_pkg::*;
(
  input  logic                clk,
  input  logic                sync_reset,
  input  logic [SIZE_W-1:0]   fft_size,

  input  logic                s_valid,
  input  logic [SAMPLE_W-1:0] s_data,
  input  logic [PHASE_W-1:0]  s_phase,
  input  logic                s_last,
  output logic                s_ready,

  input  logic                r_valid,
  input  logic [COEF_W-1:0]   r_data,
  input  logic                r_last,
  output logic                r_ready,

  output logic                m_valid,
  output logic [SAMPLE_W-1:0] m_data,
  output logic [PHASE_W-1:0]  m_phase,
  output logic                m_last,
  input  logic                m_ready
);

  logic                            almost_full;
  logic                            s_take;
  logic                            arm_valid;
  sample_t                         arm_sample;
  logic [PHASE_W-1:0]              arm_phase;
  logic                            arm_last;
  logic                            hist_valid;
  sample_t [NUM_TAPS-1:0]          hist_taps;
  logic [PHASE_W-1:0]              hist_phase;
  logic                            hist_last;
  logic [NUM_TAPS-1:0][COEF_W-1:0] coefs;
  logic                            res_valid;
  sample_t                         res_data;
  logic [PHASE_W-1:0]              res_phase;
  logic                            res_last;

  assign s_ready = ~almost_full;
  assign s_take = s_valid & s_ready;

  arm_feeder arm_feeder_inst (
    .clk(clk), .sync_reset(sync_reset), .fft_size(fft_size),
    .in_valid(s_take), .in_data(s_data), .in_phase(s_phase), .in_last(s_last),
    .arm_valid(arm_valid), .arm_sample(arm_sample), .arm_phase(arm_phase), .arm_last(arm_last)
  );

  tap_history tap_history_inst (
    .clk(clk), .sync_reset(sync_reset),
    .arm_valid(arm_valid), .arm_sample(arm_sample), .arm_phase(arm_phase), .arm_last(arm_last),
    .hist_valid(hist_valid), .hist_taps(hist_taps), .hist_phase(hist_phase),
    .hist_last(hist_last)
  );

  // coefficients are looked up alongside the history update.
  coef_bank coef_bank_inst (
    .clk(clk), .sync_reset(sync_reset),
    .r_valid(r_valid), .r_data(r_data), .r_last(r_last), .r_ready(r_ready),
    .rd_phase(arm_phase), .rd_coefs(coefs)
  );

  polyphase_mac polyphase_mac_inst (
    .clk(clk), .sync_reset(sync_reset),
    .hist_valid(hist_valid), .hist_taps(hist_taps), .hist_phase(hist_phase),
    .hist_last(hist_last), .coefs(coefs),
    .res_valid(res_valid), .res_data(res_data), .res_phase(res_phase), .res_last(res_last)
  );

  stream_fifo stream_fifo_inst (
    .clk(clk), .sync_reset(sync_reset),
    .wr_valid(res_valid), .wr_data(res_data), .wr_phase(res_phase), .wr_last(res_last),
    .almost_full(almost_full),
    .m_valid(m_valid), .m_data(m_data), .m_phase(m_phase), .m_last(m_last), .m_ready(m_ready)
  );

endmodule

//--- logic/stream_fifo.sv
// First-word-fall-through output FIFO whose almost-full flag throttles the input stream.
module stream_fifo
  import pfb_pkg::*;
(
  input  logic                clk,
  input  logic                sync_reset,
  input  logic                wr_valid,
  input  sample_t             wr_data,
  input  logic [PHASE_W-1:0]  wr_phase,
  input  logic                wr_last,
  output logic                almost_full,
  output logic                m_valid,
  output logic [SAMPLE_W-1:0] m_data,
  output logic [PHASE_W-1:0]  m_phase,
  output logic                m_last,
  input  logic                m_ready
);

  logic [SAMPLE_W-1:0]               data_mem [FIFO_DEPTH];
  logic [PHASE_W-1:0]                phase_mem [FIFO_DEPTH];
  logic                              last_mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0]   count;
  logic                              wr_en;
  logic                              rd_en;

  assign m_valid = (count != '0);
  assign rd_en = m_valid & m_ready;
  assign wr_en = wr_valid & (int'(count) < FIFO_DEPTH);
  assign almost_full = (int'(count) >= ALMOST_FULL_LEVEL);

  // head entry is presented directly.
  assign m_data = data_mem[rd_ptr];
  assign m_phase = phase_mem[rd_ptr];
  assign m_last = last_mem[rd_ptr];

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      for (int k = 0; k < FIFO_DEPTH; k++) begin
        data_mem[k] <= '0;
        phase_mem[k] <= '0;
        last_mem[k] <= 1'b0;
      end
    end else begin
      if (wr_en) begin
        data_mem[wr_ptr] <= wr_data.raw;
        phase_mem[wr_ptr] <= wr_phase;
        last_mem[wr_ptr] <= wr_last;
        wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the almost-full slack must absorb every result still in the pipeline.
  a_no_write_when_full: assert property (@(posedge clk) disable iff (sync_reset)
    wr_valid |-> int'(count) < FIFO_DEPTH);

endmodule

//--- logic/polyphase_mac.sv
// Two-stage I and Q multiply-accumulate with rounding and saturation to 16 bits.
module polyphase_mac
  import pfb_pkg::*;
(
  input  logic                            clk,
  input  logic                            sync_reset,
  input  logic                            hist_valid,
  input  sample_t [NUM_TAPS-1:0]          hist_taps,
  input  logic [PHASE_W-1:0]              hist_phase,
  input  logic                            hist_last,
  input  logic [NUM_TAPS-1:0][COEF_W-1:0] coefs,
  output logic                            res_valid,
  output sample_t                         res_data,
  output logic [PHASE_W-1:0]              res_phase,
  output logic                            res_last
);

  logic signed [COEF_W+IQ_W-1:0] prod_i [NUM_TAPS];
  logic signed [COEF_W+IQ_W-1:0] prod_q [NUM_TAPS];
  logic                          prod_valid;
  logic [PHASE_W-1:0]            prod_phase;
  logic                          prod_last;
  logic signed [ACC_W-1:0]       acc_i;
  logic signed [ACC_W-1:0]       acc_q;

  // round half up, drop the fraction, clamp to the signed output range.
  function automatic logic signed [IQ_W-1:0] round_sat(input logic signed [ACC_W-1:0] acc);
    logic signed [ACC_W-1:0] bias;
    logic signed [ACC_W-1:0] shifted;
    bias = '0;
    bias[COEF_FRAC-1] = 1'b1;
    shifted = (acc + bias) >>> COEF_FRAC;
    if (&shifted[ACC_W-1:IQ_W-1] || ~|shifted[ACC_W-1:IQ_W-1]) begin
      round_sat = shifted[IQ_W-1:0];
    end else if (shifted[ACC_W-1]) begin
      round_sat = {1'b1, {(IQ_W-1){1'b0}}};
    end else begin
      round_sat = {1'b0, {(IQ_W-1){1'b1}}};
    end
  endfunction

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      prod_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      prod_valid <= hist_valid;
      res_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hist_valid) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        prod_i[k] <= $signed(coefs[k]) * hist_taps[k].iq.i;
        prod_q[k] <= $signed(coefs[k]) * hist_taps[k].iq.q;
      end
      prod_phase <= hist_phase;
      prod_last <= hist_last;
    end
  end

  always_comb begin
    acc_i = '0;
    acc_q = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc_i = acc_i + prod_i[k];
      acc_q = acc_q + prod_q[k];
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      res_data.iq.i <= round_sat(acc_i);
      res_data.iq.q <= round_sat(acc_q);
      res_phase <= prod_phase;
      res_last <= prod_last;
    end
  end

endmodule

//--- logic/coef_bank.sv
// Reloadable coefficient store, written by the reload stream and read by phase.
module coef_bank
  import pfb_pkg::*;
(
  input  logic                             clk,
  input  logic                             sync_reset,
  input  logic                             r_valid,
  input  logic [COEF_W-1:0]                r_data,
  input  logic                             r_last,
  output logic                             r_ready,
  input  logic [PHASE_W-1:0]               rd_phase,
  output logic [NUM_TAPS-1:0][COEF_W-1:0]  rd_coefs
);

  logic                   take;
  logic [COEF_ADDR_W-1:0] coef_idx;
  logic [COEF_W-1:0]      coef_mem [NUM_TAPS][MAX_PHASES];

  assign take = r_valid & r_ready;

  // upper index bits pick the tap, lower bits the phase.
  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      r_ready <= 1'b0;
      coef_idx <= '0;
      for (int t = 0; t < NUM_TAPS; t++) begin
        for (int p = 0; p < MAX_PHASES; p++) begin
          coef_mem[t][p] <= '0;
        end
      end
    end else begin
      r_ready <= 1'b1;
      if (take) begin
        coef_mem[coef_idx[COEF_ADDR_W-1:PHASE_W]][coef_idx[PHASE_W-1:0]] <= r_data;
        if (r_last || int'(coef_idx) == COEF_COUNT - 1) begin
          coef_idx <= '0;
        end else begin
          coef_idx <= coef_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < NUM_TAPS; t++) begin
      rd_coefs[t] <= coef_mem[t][rd_phase];
    end
  end

  // the last word of a full bank must close the reload.
  a_index_in_range: assert property (@(posedge clk) disable iff (sync_reset)
    take && int'(coef_idx) == COEF_COUNT - 1 |-> r_last);

endmodule

//--- logic/tap_history.sv
// Per-phase shift history holding the most recent arm samples for each filter arm.
module tap_history
  import pfb_pkg::*;
(
  input  logic                   clk,
  input  logic                   sync_reset,
  input  logic                   arm_valid,
  input  sample_t                arm_sample,
  input  logic [PHASE_W-1:0]     arm_phase,
  input  logic                   arm_last,
  output logic                   hist_valid,
  output sample_t [NUM_TAPS-1:0] hist_taps,
  output logic [PHASE_W-1:0]     hist_phase,
  output logic                   hist_last
);

  // entry 0 of a row is the newest sample.
  sample_t [NUM_TAPS-1:0] rows [MAX_PHASES];
  sample_t [NUM_TAPS-1:0] shifted;

  assign shifted = {rows[arm_phase][NUM_TAPS-2:0], arm_sample};

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      hist_valid <= 1'b0;
    end else begin
      hist_valid <= arm_valid;
    end
  end

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      for (int k = 0; k < MAX_PHASES; k++) begin
        rows[k] <= '0;
      end
    end else if (arm_valid) begin
      rows[arm_phase] <= shifted;
    end
  end

  // the row leaves already updated, so the newest tap is this sample.
  always_ff @(posedge clk) begin
    if (arm_valid) begin
      hist_taps <= shifted;
      hist_phase <= arm_phase;
      hist_last <= arm_last;
    end
  end

endmodule

//--- logic/arm_feeder.sv
// Phase masking and bottom-half sample substitution that feed the filter arms.
module arm_feeder
  import pfb_pkg::*;
(
  input  logic               clk,
  input  logic               sync_reset,
  input  logic [SIZE_W-1:0]  fft_size,
  input  logic               in_valid,
  input  sample_t            in_data,
  input  logic [PHASE_W-1:0] in_phase,
  input  logic               in_last,
  output logic               arm_valid,
  output sample_t            arm_sample,
  output logic [PHASE_W-1:0] arm_phase,
  output logic               arm_last
);

  logic [SIZE_W-1:0]   size_mask;
  logic [SIZE_W-1:0]   size_half;
  logic                stage_valid;
  sample_t             stage_data;
  logic [PHASE_W-1:0]  stage_phase;
  logic                stage_last;
  logic                bottom_half;
  logic [SAMPLE_W-1:0] delay_mem [MAX_PHASES];

  assign size_mask = fft_size - 1'b1;
  assign size_half = fft_size >> 1;
  // with p below fft_size, the half bit alone marks the upper half.
  assign bottom_half = |(stage_phase & size_half[PHASE_W-1:0]);

  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      stage_valid <= 1'b0;
      arm_valid <= 1'b0;
    end else begin
      stage_valid <= in_valid;
      arm_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage_data <= in_data;
      stage_phase <= in_phase & size_mask[PHASE_W-1:0];
      stage_last <= in_last;
    end
    if (stage_valid) begin
      arm_phase <= stage_phase;
      arm_last <= stage_last;
      if (bottom_half) begin
        arm_sample.raw <= delay_mem[stage_phase];
      end else begin
        arm_sample <= stage_data;
      end
    end
  end

  // one revolution of delay per phase, read before it is overwritten.
  always_ff @(posedge clk or posedge sync_reset) begin
    if (sync_reset) begin
      for (int k = 0; k < MAX_PHASES; k++) begin
        delay_mem[k] <= '0;
      end
    end else if (stage_valid) begin
      delay_mem[stage_phase] <= stage_data.raw;
    end
  end

  a_fft_size_legal: assert property (@(posedge clk) disable iff (sync_reset)
    in_valid |-> (fft_size == SIZE_W'(4) || fft_size == SIZE_W'(8) || fft_size == SIZE_W'(16)));

endmodule

//--- logic/pfb_pkg.sv
// Shared widths, sizes and the complex sample type for the polyphase filter bank RTL.
package pfb_pkg;

  // sample and coefficient widths.
  localparam int SAMPLE_W = 32;
  localparam int IQ_W = 16;
  localparam int COEF_W = 18;
  localparam int COEF_FRAC = 17;

  // bank geometry.
  localparam int NUM_TAPS = 4;
  localparam int MAX_PHASES = 16;
  localparam int PHASE_W = 4;
  localparam int SIZE_W = 5;

  // one full reload covers every tap of every phase.
  localparam int COEF_COUNT = NUM_TAPS * MAX_PHASES;
  localparam int COEF_ADDR_W = 6;

  // multiply-accumulate width.
  localparam int ACC_W = 40;

  // output buffering.
  localparam int FIFO_DEPTH = 16;
  localparam int ALMOST_FULL_LEVEL = 10;

  // a sample word, seen either whole or as its I and Q halves.
  typedef union packed {
    logic [SAMPLE_W-1:0] raw;
    struct packed {
      logic signed [IQ_W-1:0] i;
      logic signed [IQ_W-1:0] q;
    } iq;
  } sample_t;

endpackage
